// File: source/fir_dsp_pkg.sv
`default_nettype none

package fir_dsp_pkg;

    // Datapath widths
    localparam int A_W    = 26;
    localparam int D_W    = 26;
    localparam int B_W    = 18;
    localparam int PRE_W  = 27;
    localparam int PROD_W = 45;
    localparam int P_W    = 48;

    // AXI4-Lite widths
    localparam int AXI_AW = 4;
    localparam int AXI_DW = 32;

    // Register map
    localparam logic [AXI_AW-1:0] ADDR_CTRL        = 4'h0;
    localparam logic [AXI_AW-1:0] ADDR_COEF_STAGE  = 4'h4;
    localparam logic [AXI_AW-1:0] ADDR_UPDATE      = 4'h8;
    localparam logic [AXI_AW-1:0] ADDR_COEF_ACTIVE = 4'hC;

    // D+A with C added after reset
    localparam logic [AXI_DW-1:0] CTRL_RESET = 32'h0000_000A;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic add_pcin;
        logic use_c;
        logic subtract_c;
        logic use_d;
        logic subtract_a;
    } dsp_mode_t;

    // Host sees the whole word, datapath sees the mode bits
    typedef union packed {
        logic [AXI_DW-1:0] raw;
        struct packed {
            logic [AXI_DW-6:0] reserved;
            dsp_mode_t         mode;
        } fields;
    } dsp_ctrl_u;

    typedef struct packed {
        dsp_mode_t              mode;
        logic signed [B_W-1:0]  coef;
    } dsp_cfg_t;

    typedef struct packed {
        logic                   valid;
        logic signed [A_W-1:0]  a;
        logic signed [D_W-1:0]  d;
        logic [P_W-1:0]         c;
    } tap_in_t;

    typedef struct packed {
        logic                   valid;
        logic [P_W-1:0]         p;
    } tap_out_t;

    typedef struct packed {
        logic                   valid;
        logic signed [PRE_W-1:0] pre;
        logic [P_W-1:0]         c;
    } pre_stage_t;

    typedef struct packed {
        logic               awvalid;
        logic [AXI_AW-1:0]  awaddr;
        logic               wvalid;
        logic [AXI_DW-1:0]  wdata;
        logic               bready;
        logic               arvalid;
        logic [AXI_AW-1:0]  araddr;
        logic               rready;
    } axil_req_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [AXI_DW-1:0]  rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: source/fir_dsp_cfg_regs.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_cfg_regs (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  fir_dsp_pkg::axil_req_t   axil_req_i,
    output fir_dsp_pkg::axil_rsp_t   axil_rsp_o,
    output fir_dsp_pkg::dsp_cfg_t    cfg_o
);

    fir_dsp_pkg::dsp_ctrl_u                 ctrl_q;
    logic signed [fir_dsp_pkg::B_W-1:0]     coef_stage_q;
    logic signed [fir_dsp_pkg::B_W-1:0]     coef_active_q;

    logic                                   bvalid_q;
    logic [1:0]                             bresp_q;
    logic                                   rvalid_q;
    logic [1:0]                             rresp_q;
    logic [fir_dsp_pkg::AXI_DW-1:0]         rdata_q;

    logic                                   wr_accept;
    logic                                   rd_accept;
    logic                                   wr_ok;
    logic                                   rd_ok;
    logic [fir_dsp_pkg::AXI_DW-1:0]         rd_data;

    // Address and data must arrive together, one write outstanding
    assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;
    assign rd_accept = axil_req_i.arvalid & ~rvalid_q;

    // Active coefficient is read-only
    always_comb begin
        case (axil_req_i.awaddr)
            fir_dsp_pkg::ADDR_CTRL,
            fir_dsp_pkg::ADDR_COEF_STAGE,
            fir_dsp_pkg::ADDR_UPDATE: wr_ok = 1'b1;
            default:                  wr_ok = 1'b0;
        endcase
    end

    always_comb begin
        rd_ok   = 1'b1;
        rd_data = '0;
        case (axil_req_i.araddr)
            fir_dsp_pkg::ADDR_CTRL:        rd_data = ctrl_q.raw;
            fir_dsp_pkg::ADDR_COEF_STAGE:  rd_data = 32'(coef_stage_q);
            fir_dsp_pkg::ADDR_UPDATE:      rd_data = '0;
            fir_dsp_pkg::ADDR_COEF_ACTIVE: rd_data = 32'(coef_active_q);
            default:                       rd_ok   = 1'b0;
        endcase
    end

    // Write side and coefficient load/update
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q.raw    <= fir_dsp_pkg::CTRL_RESET;
            coef_stage_q  <= '0;
            coef_active_q <= '0;
            bvalid_q      <= 1'b0;
            bresp_q       <= fir_dsp_pkg::RESP_OKAY;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_ok ? fir_dsp_pkg::RESP_OKAY : fir_dsp_pkg::RESP_SLVERR;
                case (axil_req_i.awaddr)
                    fir_dsp_pkg::ADDR_CTRL: begin
                        ctrl_q.raw <= axil_req_i.wdata;
                    end
                    fir_dsp_pkg::ADDR_COEF_STAGE: begin
                        coef_stage_q <= axil_req_i.wdata[fir_dsp_pkg::B_W-1:0];
                    end
                    // Update strobe, data is ignored
                    fir_dsp_pkg::ADDR_UPDATE: begin
                        coef_active_q <= coef_stage_q;
                    end
                    default: begin
                    end
                endcase
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Read response state
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            rresp_q  <= fir_dsp_pkg::RESP_OKAY;
        end else if (rd_accept) begin
            rvalid_q <= 1'b1;
            rresp_q  <= rd_ok ? fir_dsp_pkg::RESP_OKAY : fir_dsp_pkg::RESP_SLVERR;
        end else if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_accept) begin
            rdata_q <= rd_data;
        end
    end

    assign axil_rsp_o.awready = wr_accept;
    assign axil_rsp_o.wready  = wr_accept;
    assign axil_rsp_o.bvalid  = bvalid_q;
    assign axil_rsp_o.bresp   = bresp_q;
    assign axil_rsp_o.arready = rd_accept;
    assign axil_rsp_o.rvalid  = rvalid_q;
    assign axil_rsp_o.rdata   = rdata_q;
    assign axil_rsp_o.rresp   = rresp_q;

    assign cfg_o.mode = ctrl_q.fields.mode;
    assign cfg_o.coef = coef_active_q;

endmodule

`default_nettype wire

// File: source/fir_dsp_preadd.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_preadd (
    input  wire                       clk_i,
    input  wire                       rst_n_i,
    input  fir_dsp_pkg::tap_in_t      in_i,
    input  fir_dsp_pkg::dsp_cfg_t     cfg_i,
    output fir_dsp_pkg::pre_stage_t   pre_o
);

    logic                                valid_q;
    fir_dsp_pkg::tap_in_t                in_q;
    logic signed [fir_dsp_pkg::PRE_W-1:0] a_ext;
    logic signed [fir_dsp_pkg::PRE_W-1:0] d_ext;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_i.valid;
        end
    end

    // Sample registers, only loaded with a valid item
    always_ff @(posedge clk_i) begin
        if (in_i.valid) begin
            in_q <= in_i;
        end
    end

    // One guard bit so D+A cannot overflow
    assign a_ext = {in_q.a[fir_dsp_pkg::A_W-1], in_q.a};

    // Without D the pre-adder passes +A or -A
    assign d_ext = cfg_i.mode.use_d ? {in_q.d[fir_dsp_pkg::D_W-1], in_q.d} : '0;

    always_comb begin
        pre_o.valid = valid_q;
        pre_o.c     = in_q.c;
        if (cfg_i.mode.subtract_a) begin
            pre_o.pre = d_ext - a_ext;
        end else begin
            pre_o.pre = d_ext + a_ext;
        end
    end

endmodule

`default_nettype wire

// File: source/fir_dsp_mult_acc.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_mult_acc (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  fir_dsp_pkg::pre_stage_t       pre_i,
    input  fir_dsp_pkg::dsp_cfg_t         cfg_i,
    input  wire [fir_dsp_pkg::P_W-1:0]    pcin_i,
    output fir_dsp_pkg::tap_out_t         p_o
);

    logic                                    valid_m_q;
    logic signed [fir_dsp_pkg::PROD_W-1:0]   prod_q;
    logic [fir_dsp_pkg::P_W-1:0]             c_m_q;
    logic                                    valid_p_q;
    logic [fir_dsp_pkg::P_W-1:0]             p_q;

    logic [fir_dsp_pkg::P_W-1:0]             prod_ext;
    logic [fir_dsp_pkg::P_W-1:0]             c_term;
    logic [fir_dsp_pkg::P_W-1:0]             pcin_term;
    logic                                    carry_in;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_m_q <= 1'b0;
            valid_p_q <= 1'b0;
        end else begin
            valid_m_q <= pre_i.valid;
            valid_p_q <= valid_m_q;
        end
    end

    // Product register, C delayed alongside
    always_ff @(posedge clk_i) begin
        if (pre_i.valid) begin
            prod_q <= $signed(pre_i.pre) * $signed(cfg_i.coef);
            c_m_q  <= pre_i.c;
        end
    end

    assign prod_ext = {{(fir_dsp_pkg::P_W - fir_dsp_pkg::PROD_W){prod_q[fir_dsp_pkg::PROD_W-1]}},
                       prod_q};

    // Subtracting C is the inverted word plus a carry of one
    assign c_term    = cfg_i.mode.use_c ? (cfg_i.mode.subtract_c ? ~c_m_q : c_m_q) : '0;
    assign carry_in  = cfg_i.mode.use_c & cfg_i.mode.subtract_c;
    assign pcin_term = cfg_i.mode.add_pcin ? pcin_i : '0;

    always_ff @(posedge clk_i) begin
        if (valid_m_q) begin
            p_q <= prod_ext + c_term + pcin_term + {{(fir_dsp_pkg::P_W-1){1'b0}}, carry_in};
        end
    end

    assign p_o.valid = valid_p_q;
    assign p_o.p     = p_q;

endmodule

`default_nettype wire

// File: source/fir_dsp_tap.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_tap (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  fir_dsp_pkg::axil_req_t        axil_req_i,
    output fir_dsp_pkg::axil_rsp_t        axil_rsp_o,
    input  fir_dsp_pkg::tap_in_t          in_i,
    input  wire [fir_dsp_pkg::P_W-1:0]    pcin_i,
    output fir_dsp_pkg::tap_out_t         p_o
);

    fir_dsp_pkg::dsp_cfg_t     cfg;
    fir_dsp_pkg::pre_stage_t   pre_stage;

    // Mode word and coefficients
    fir_dsp_cfg_regs u_cfg_regs (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .axil_req_i (axil_req_i),
        .axil_rsp_o (axil_rsp_o),
        .cfg_o      (cfg)
    );

    // Input registers and pre-adder
    fir_dsp_preadd u_preadd (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .in_i    (in_i),
        .cfg_i   (cfg),
        .pre_o   (pre_stage)
    );

    // Multiplier, post-adder and P register, P doubles as cascade out
    fir_dsp_mult_acc u_mult_acc (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pre_i   (pre_stage),
        .cfg_i   (cfg),
        .pcin_i  (pcin_i),
        .p_o     (p_o)
    );

endmodule

`default_nettype wire

// File: verif/fir_dsp_tap_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_tap_checker (
    input wire                      clk_i,
    input wire                      rst_n_i,
    input fir_dsp_pkg::tap_in_t     in_i,
    input fir_dsp_pkg::tap_out_t    p_o,
    input fir_dsp_pkg::axil_req_t   axil_req_i,
    input fir_dsp_pkg::axil_rsp_t   axil_rsp_o
);

    // Three register stages from the input item to P
    valid_in_to_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_i.valid |-> ##3 p_o.valid)
        else $error("p_o.valid did not follow in_i.valid after three cycles");

    no_extra_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !in_i.valid |-> ##3 !p_o.valid)
        else $error("p_o.valid raised without an input item three cycles before");

    bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_o.rvalid && !axil_req_i.rready |=> axil_rsp_o.rvalid)
        else $error("rvalid dropped before rready");

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> !p_o.valid && !axil_rsp_o.bvalid && !axil_rsp_o.rvalid)
        else $error("valid output or response seen during reset");

endmodule

bind fir_dsp_tap fir_dsp_tap_checker u_checker (.*);

`default_nettype wire

// File: verif/fir_dsp_tap_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_tap_monitor (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  fir_dsp_pkg::tap_out_t   p_i,
    output int                      error_cnt_o,
    output int                      pending_o
);

    logic [fir_dsp_pkg::P_W-1:0]    exp_q [$];
    logic [fir_dsp_pkg::P_W-1:0]    exp_p;

    initial begin
        error_cnt_o = 0;
        pending_o   = 0;
    end

    task automatic expect_value(input logic [fir_dsp_pkg::P_W-1:0] value);
        exp_q.push_back(value);
        pending_o = exp_q.size();
    endtask

    task automatic compare_word(input string what, input logic [fir_dsp_pkg::P_W-1:0] got,
                                input logic [fir_dsp_pkg::P_W-1:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
            error_cnt_o++;
        end
    endtask

    // Anything still queued after the drain never came out
    task automatic report_missing();
        if (exp_q.size() != 0) begin
            $display("Missing outputs: %0d expected P values never appeared", exp_q.size());
            error_cnt_o++;
            exp_q.delete();
            pending_o = 0;
        end
    endtask

    // Mid-cycle sampling, P is stable here
    always @(negedge clk_i) begin
        if (rst_n_i && p_i.valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output on p_o at %0t with no value expected", $time);
                error_cnt_o++;
            end else begin
                exp_p = exp_q.pop_front();
                pending_o = exp_q.size();
                compare_word("p_o", p_i.p, exp_p);
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/fir_dsp_tap_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fir_dsp_tap_tb;

    localparam int MAX_CYCLES = 2500;

    logic                                   clk;
    logic                                   rst_n;
    fir_dsp_pkg::axil_req_t                 axil_req;
    fir_dsp_pkg::axil_rsp_t                 axil_rsp;
    fir_dsp_pkg::tap_in_t                   tap_in;
    logic [fir_dsp_pkg::P_W-1:0]            pcin;
    fir_dsp_pkg::tap_out_t                  tap_out;

    int                                     error_cnt;
    int                                     pending_cnt;
    int                                     cycle_cnt;
    int                                     test_num;
    int                                     tests_failed;
    int                                     test_base;
    logic [31:0]                            lfsr_state;

    // Host-side copy of the register contents
    fir_dsp_pkg::dsp_ctrl_u                 ctrl_m;
    logic signed [fir_dsp_pkg::B_W-1:0]     coef_stage_m;
    logic signed [fir_dsp_pkg::B_W-1:0]     coef_active_m;

    fir_dsp_tap uut (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp),
        .in_i       (tap_in),
        .pcin_i     (pcin),
        .p_o        (tap_out)
    );

    fir_dsp_tap_monitor u_monitor (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .p_i         (tap_out),
        .error_cnt_o (error_cnt),
        .pending_o   (pending_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        cycle_cnt = 0;
        wait (cycle_cnt == MAX_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // P = (pre-add result * coef) +/- C + PCIN, wrapped to 48 bits
    function automatic logic [fir_dsp_pkg::P_W-1:0] expected_p(
        input logic signed [fir_dsp_pkg::A_W-1:0] a,
        input logic signed [fir_dsp_pkg::D_W-1:0] d,
        input logic [fir_dsp_pkg::P_W-1:0]        c,
        input logic [fir_dsp_pkg::P_W-1:0]        pc,
        input fir_dsp_pkg::dsp_mode_t             m,
        input logic signed [fir_dsp_pkg::B_W-1:0] coef
    );
        longint pre;
        longint acc;
        pre = m.use_d ? longint'(d) : 0;
        pre = m.subtract_a ? pre - longint'(a) : pre + longint'(a);
        acc = pre * longint'(coef);
        if (m.use_c) begin
            acc = m.subtract_c ? acc - longint'(c) : acc + longint'(c);
        end
        if (m.add_pcin) begin
            acc = acc + longint'(pc);
        end
        return acc[fir_dsp_pkg::P_W-1:0];
    endfunction

    task automatic axi_write(input logic [fir_dsp_pkg::AXI_AW-1:0] addr,
                             input logic [fir_dsp_pkg::AXI_DW-1:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.bready  <= 1'b0;
        do @(posedge clk); while (!axil_rsp.awready);
        u_monitor.compare_word("wready at write acceptance", axil_rsp.wready, 1'b1);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        do @(posedge clk); while (!axil_rsp.bvalid);
        resp = axil_rsp.bresp;
        // Response taken one cycle late so bvalid has to hold
        axil_req.bready <= 1'b1;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [fir_dsp_pkg::AXI_AW-1:0] addr,
                            output logic [fir_dsp_pkg::AXI_DW-1:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b0;
        do @(posedge clk); while (!axil_rsp.arready);
        axil_req.arvalid <= 1'b0;
        do @(posedge clk); while (!axil_rsp.rvalid);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        // Response taken one cycle late so rvalid has to hold
        axil_req.rready <= 1'b1;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic write_check(input logic [fir_dsp_pkg::AXI_AW-1:0] addr,
                               input logic [fir_dsp_pkg::AXI_DW-1:0] data,
                               input logic [1:0] exp_resp);
        logic [1:0] r;
        axi_write(addr, data, r);
        u_monitor.compare_word($sformatf("bresp of write to 0x%h", addr), r, exp_resp);
    endtask

    task automatic read_check(input logic [fir_dsp_pkg::AXI_AW-1:0] addr,
                              input logic [fir_dsp_pkg::AXI_DW-1:0] exp_data,
                              input logic [1:0] exp_resp);
        logic [fir_dsp_pkg::AXI_DW-1:0] data;
        logic [1:0]                     r;
        axi_read(addr, data, r);
        u_monitor.compare_word($sformatf("rresp of read from 0x%h", addr), r, exp_resp);
        if (exp_resp == fir_dsp_pkg::RESP_OKAY) begin
            u_monitor.compare_word($sformatf("rdata of read from 0x%h", addr), data, exp_data);
        end
    endtask

    task automatic set_mode(input fir_dsp_pkg::dsp_mode_t m);
        write_check(fir_dsp_pkg::ADDR_CTRL, {27'b0, m}, fir_dsp_pkg::RESP_OKAY);
        ctrl_m.raw = {27'b0, m};
    endtask

    task automatic stage_coef(input logic signed [fir_dsp_pkg::B_W-1:0] k);
        write_check(fir_dsp_pkg::ADDR_COEF_STAGE, 32'(k), fir_dsp_pkg::RESP_OKAY);
        coef_stage_m = k;
    endtask

    task automatic update_coef();
        write_check(fir_dsp_pkg::ADDR_UPDATE, 32'h0, fir_dsp_pkg::RESP_OKAY);
        coef_active_m = coef_stage_m;
    endtask

    // Back-to-back items, then a bounded drain of the pipeline
    task automatic run_stream(input int n);
        fir_dsp_pkg::tap_in_t          item;
        logic [fir_dsp_pkg::P_W-1:0]   pc;
        logic [fir_dsp_pkg::P_W-1:0]   pc_q [$];
        int                            wait_cnt;
        for (int j = 0; j < n + 3; j++) begin
            @(posedge clk);
            item = '0;
            if (j < n) begin
                item.valid = 1'b1;
                item.a     = random_bits(fir_dsp_pkg::A_W);
                item.d     = random_bits(fir_dsp_pkg::D_W);
                item.c     = random_bits(fir_dsp_pkg::P_W);
                pc         = random_bits(fir_dsp_pkg::P_W);
                pc_q.push_back(pc);
                u_monitor.expect_value(expected_p(item.a, item.d, item.c, pc,
                                                  ctrl_m.fields.mode, coef_active_m));
            end
            tap_in <= item;
            // P register takes PCIN three edges after the item is driven,
            // so its PCIN goes out one edge before that
            if (j >= 2 && j < n + 2) begin
                pcin <= pc_q.pop_front();
            end
        end
        wait_cnt = 0;
        while (pending_cnt != 0 && wait_cnt < 8) begin
            @(posedge clk);
            wait_cnt++;
        end
        u_monitor.report_missing();
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (error_cnt != test_base) begin
            tests_failed++;
        end
        $display("Test %0d %s: %s, %0d errors", test_num, name,
                 (error_cnt == test_base) ? "passed" : "failed", error_cnt - test_base);
        test_base = error_cnt;
    endtask

    initial begin
        rst_n         = 1'b1;
        axil_req      = '0;
        tap_in        = '0;
        pcin          = '0;
        lfsr_state    = 32'hbfd1377b;
        ctrl_m.raw    = fir_dsp_pkg::CTRL_RESET;
        coef_stage_m  = '0;
        coef_active_m = '0;
        test_num      = 0;
        tests_failed  = 0;
        test_base     = 0;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        read_check(fir_dsp_pkg::ADDR_CTRL, fir_dsp_pkg::CTRL_RESET, fir_dsp_pkg::RESP_OKAY);
        read_check(fir_dsp_pkg::ADDR_COEF_STAGE, 32'h0, fir_dsp_pkg::RESP_OKAY);
        read_check(fir_dsp_pkg::ADDR_COEF_ACTIVE, 32'h0, fir_dsp_pkg::RESP_OKAY);
        finish_test("reset readback");

        stage_coef(random_bits(fir_dsp_pkg::B_W));
        update_coef();
        run_stream(64);
        finish_test("default mode");

        // Staged value must stay invisible until the update strobe
        stage_coef(random_bits(fir_dsp_pkg::B_W));
        read_check(fir_dsp_pkg::ADDR_COEF_ACTIVE, 32'(coef_active_m), fir_dsp_pkg::RESP_OKAY);
        run_stream(16);
        update_coef();
        read_check(fir_dsp_pkg::ADDR_COEF_ACTIVE, 32'(coef_active_m), fir_dsp_pkg::RESP_OKAY);
        run_stream(16);
        finish_test("two-stage coefficient");

        // D-A, then +A, then -A
        set_mode(5'b01011);
        run_stream(16);
        set_mode(5'b01000);
        run_stream(16);
        set_mode(5'b01001);
        run_stream(16);
        finish_test("pre-adder modes");

        // Subtract C, then no C, then C plus PCIN
        set_mode(5'b01110);
        run_stream(16);
        set_mode(5'b00010);
        run_stream(16);
        set_mode(5'b11010);
        run_stream(16);
        finish_test("post-adder modes");

        set_mode(5'b10101);
        stage_coef(random_bits(fir_dsp_pkg::B_W));
        write_check(4'h2, 32'hffff_ffff, fir_dsp_pkg::RESP_SLVERR);
        write_check(fir_dsp_pkg::ADDR_COEF_ACTIVE, 32'h0001_2345, fir_dsp_pkg::RESP_SLVERR);
        read_check(fir_dsp_pkg::ADDR_CTRL, ctrl_m.raw, fir_dsp_pkg::RESP_OKAY);
        read_check(fir_dsp_pkg::ADDR_COEF_STAGE, 32'(coef_stage_m), fir_dsp_pkg::RESP_OKAY);
        read_check(fir_dsp_pkg::ADDR_COEF_ACTIVE, 32'(coef_active_m), fir_dsp_pkg::RESP_OKAY);
        read_check(4'h6, 32'h0, fir_dsp_pkg::RESP_SLVERR);
        finish_test("address errors");

        $display("Tests run: %0d, failed: %0d, errors: %0d", test_num, tests_failed, error_cnt);
        if (error_cnt == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fir_dsp_tap.f
source/fir_dsp_pkg.sv
source/fir_dsp_cfg_regs.sv
source/fir_dsp_preadd.sv
source/fir_dsp_mult_acc.sv
source/fir_dsp_tap.sv
verif/fir_dsp_tap_checker.sv
verif/fir_dsp_tap_monitor.sv
verif/fir_dsp_tap_tb.sv
